// File: rv_int_core.f
verilog/rv_int_pkg.sv
verilog/insn_queue.sv
verilog/insn_decode.sv
verilog/reg_file.sv
verilog/arith_unit.sv
verilog/shift_logic_unit.sv
verilog/writeback_select.sv
verilog/rv_int_core.sv
verification/rv_int_core_tb.sv

// File: verification/rv_int_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_int_core_tb
  import rv_int_pkg::*;
();

  logic clk;
  logic rst;
  logic insn_valid;
  word_t insn;
  logic insn_credit;
  logic retire_valid;
  reg_idx_t retire_rd;
  word_t retire_data;
  logic halt;

  // architectural model and expected retire stream
  word_t model_regs [num_regs];
  reg_idx_t exp_rd_q [$];
  word_t exp_data_q [$];

  int credits;
  int credits_returned;
  int retire_count;
  int sent_count;
  int cycle_count;
  int error_count;
  int check_count;
  int test_count;
  int test_errors_at_start;
  integer seed;
  string current_test;

  rv_int_core UUT (
    .clk(clk),
    .rst(rst),
    .insn_valid(insn_valid),
    .insn(insn),
    .insn_credit(insn_credit),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_equal(input string what, input word_t expected, input word_t actual);
    check_count = check_count + 1;
    if (expected !== actual) begin
      $display("** Error %s: %s expected %h, actual %h", current_test, what, expected, actual);
      error_count = error_count + 1;
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (insn_credit === 1'b1) begin
      credits = credits + 1;
      credits_returned = credits_returned + 1;
      if (credits > credit_depth) begin
        $display("%s: core returned more credits than the sender spent", current_test);
        error_count = error_count + 1;
      end
    end
    if (retire_valid === 1'b1) begin
      retire_count = retire_count + 1;
      if (exp_rd_q.size() == 0) begin
        $display("%s: retire of x%0d seen with no instruction pending", current_test,
                 retire_rd);
        error_count = error_count + 1;
      end else begin
        check_equal("retire_rd", {27'b0, exp_rd_q.pop_front()}, {27'b0, retire_rd});
        check_equal("retire_data", exp_data_q.pop_front(), retire_data);
      end
    end
  end

  // RV32I encoders
  function automatic word_t enc_r(input funct7_t f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                 input funct3_t f3, input reg_idx_t rd);
    enc_r = {f7, rs2, rs1, f3, rd, op_reg_reg};
  endfunction

  function automatic word_t enc_i(input opcode_t opc, input logic [11:0] imm,
                                 input reg_idx_t rs1, input funct3_t f3, input reg_idx_t rd);
    enc_i = {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
    enc_u = {imm, rd, op_lui};
  endfunction

  // expected result from the RV32I rules
  function automatic word_t model_result(input word_t word);
    word_t a;
    word_t b;
    word_t result;
    logic is_reg;
    logic alt;
    a = model_regs[word[19:15]];
    is_reg = (word[6:0] == op_reg_reg);
    alt = word[30];
    b = is_reg ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
    case (word[14:12])
      funct3_add: result = (is_reg && alt) ? a - b : a + b;
      funct3_sll: result = a << b[4:0];
      funct3_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      funct3_sltu: result = (a < b) ? 32'd1 : 32'd0;
      funct3_xor: result = a ^ b;
      funct3_srl: begin
        if (alt) begin
          result = $signed(a) >>> b[4:0];
        end else begin
          result = a >> b[4:0];
        end
      end
      funct3_or: result = a | b;
      default: result = a & b;
    endcase
    if (word[6:0] == op_lui) begin
      result = {word[31:12], 12'h000};
    end
    model_result = result;
  endfunction

  // sender blocks while it holds no credit
  task automatic send_insn(input word_t word);
    @(posedge clk);
    while (credits == 0) begin
      insn_valid <= 1'b0;
      @(posedge clk);
    end
    insn_valid <= 1'b1;
    insn <= word;
    credits = credits - 1;
    sent_count = sent_count + 1;
  endtask

  task automatic issue(input word_t word);
    word_t value;
    value = model_result(word);
    exp_rd_q.push_back(word[11:7]);
    exp_data_q.push_back(value);
    if (word[11:7] != 5'd0) begin
      model_regs[word[11:7]] = value;
    end
    send_insn(word);
  endtask

  // lui plus addi with the upper part rounded for the signed low half
  task automatic load_reg(input reg_idx_t rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;
    issue(enc_u(upper[31:12], rd));
    issue(enc_i(op_reg_imm, value[11:0], rd, funct3_add, rd));
  endtask

  task automatic wait_idle();
    @(posedge clk);
    insn_valid <= 1'b0;
    while (exp_rd_q.size() != 0 || credits != credit_depth) begin
      @(negedge clk);
    end
  endtask

  task automatic start_test(input string name);
    current_test = name;
    test_errors_at_start = error_count;
    test_count = test_count + 1;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", current_test,
             error_count - test_errors_at_start);
  endtask

  task automatic test_lui_x0();
    start_test("lui_x0");
    issue(enc_u(20'habcde, 5'd1));
    // x0 write still retires
    issue(enc_u(20'h12345, 5'd0));
    issue(enc_r(funct7_base, 5'd0, 5'd0, funct3_add, 5'd2));
    issue(enc_r(funct7_base, 5'd0, 5'd1, funct3_add, 5'd3));
    wait_idle();
    end_test();
  endtask

  task automatic test_reg_imm();
    word_t r;
    logic [11:0] imm;
    start_test("reg_imm");
    for (int round = 0; round < 3; round++) begin
      load_reg(5'd5, $random(seed));
      for (int k = 0; k < 8; k++) begin
        // shifts have their own test
        if (funct3_t'(k) != funct3_sll && funct3_t'(k) != funct3_srl) begin
          r = $random(seed);
          imm = {1'b1, r[10:0]};
          issue(enc_i(op_reg_imm, imm, 5'd5, funct3_t'(k), reg_idx_t'(6 + k)));
        end
      end
    end
    wait_idle();
    end_test();
  endtask

  task automatic test_shifts();
    word_t value;
    word_t amount;
    start_test("shifts");
    for (int round = 0; round < 2; round++) begin
      value = $random(seed);
      value[31] = (round == 0);
      amount = $random(seed);
      // upper bits of the amount must be ignored
      amount[8] = 1'b1;
      load_reg(5'd5, value);
      load_reg(5'd7, amount);
      issue(enc_i(op_reg_imm, {funct7_base, amount[4:0]}, 5'd5, funct3_sll, 5'd8));
      issue(enc_i(op_reg_imm, {funct7_base, amount[4:0]}, 5'd5, funct3_srl, 5'd9));
      issue(enc_i(op_reg_imm, {funct7_alt, amount[4:0]}, 5'd5, funct3_srl, 5'd10));
      issue(enc_r(funct7_base, 5'd7, 5'd5, funct3_sll, 5'd11));
      issue(enc_r(funct7_base, 5'd7, 5'd5, funct3_srl, 5'd12));
      issue(enc_r(funct7_alt, 5'd7, 5'd5, funct3_srl, 5'd13));
    end
    wait_idle();
    end_test();
  endtask

  task automatic test_reg_reg();
    start_test("reg_reg");
    for (int round = 0; round < 2; round++) begin
      for (int r = 10; r < 14; r++) begin
        load_reg(reg_idx_t'(r), $random(seed));
      end
      // each result feeds the next instruction
      issue(enc_r(funct7_base, 5'd11, 5'd10, funct3_add, 5'd14));
      issue(enc_r(funct7_alt, 5'd12, 5'd14, funct3_add, 5'd15));
      issue(enc_r(funct7_base, 5'd13, 5'd15, funct3_slt, 5'd16));
      issue(enc_r(funct7_base, 5'd15, 5'd14, funct3_sltu, 5'd17));
      issue(enc_r(funct7_base, 5'd14, 5'd17, funct3_xor, 5'd18));
      issue(enc_r(funct7_base, 5'd10, 5'd18, funct3_or, 5'd19));
      issue(enc_r(funct7_base, 5'd15, 5'd19, funct3_and, 5'd20));
      issue(enc_r(funct7_alt, 5'd20, 5'd20, funct3_add, 5'd21));
      issue(enc_r(funct7_base, 5'd11, 5'd10, funct3_slt, 5'd22));
      issue(enc_r(funct7_base, 5'd11, 5'd10, funct3_sltu, 5'd23));
    end
    wait_idle();
    end_test();
  endtask

  task automatic test_credit_flow();
    int returned_before;
    int retired_before;
    word_t imm;
    start_test("credit_flow");
    returned_before = credits_returned;
    retired_before = retire_count;
    for (int k = 0; k < credit_depth; k++) begin
      imm = k + 1;
      issue(enc_i(op_reg_imm, imm[11:0], 5'd0, funct3_add, reg_idx_t'(24 + k)));
    end
    // sender has to wait for returned credits here
    for (int k = 0; k < 4; k++) begin
      issue(enc_i(op_reg_imm, 12'hffd, reg_idx_t'(24 + k), funct3_add, reg_idx_t'(25 + k)));
    end
    wait_idle();
    check_equal("credits returned", credit_depth + 4, credits_returned - returned_before);
    check_equal("retire count", credit_depth + 4, retire_count - retired_before);
    end_test();
  endtask

  task automatic test_illegal_halt();
    int returned_before;
    int retired_before;
    start_test("illegal_halt");
    returned_before = credits_returned;
    retired_before = retire_count;
    // lw x9, 4(x1) is outside the kept set
    send_insn(enc_i(7'b0000011, 12'h004, 5'd1, 3'b010, 5'd9));
    send_insn(enc_i(op_reg_imm, 12'h001, 5'd0, funct3_add, 5'd9));
    send_insn(enc_r(funct7_base, 5'd2, 5'd1, funct3_add, 5'd9));
    @(posedge clk);
    insn_valid <= 1'b0;
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
    // window for stray credits or retires
    repeat (20) @(negedge clk);
    check_equal("halt", 1, halt);
    if (credits_returned - returned_before != 1) begin
      $display("%s: %0d credits came back, only the illegal instruction should return one",
               current_test, credits_returned - returned_before);
      error_count = error_count + 1;
    end
    if (retire_count != retired_before) begin
      $display("%s: an instruction retired after the illegal encoding", current_test);
      error_count = error_count + 1;
    end
    end_test();
  endtask

  // limit grows with the instructions sent
  initial begin
    cycle_count = 0;
    while (cycle_count <= 40 * sent_count + 100) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout after %0d cycles in %s, the core stopped responding", cycle_count,
             current_test);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    seed = 74;
    credits = credit_depth;
    credits_returned = 0;
    retire_count = 0;
    sent_count = 0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    test_errors_at_start = 0;
    current_test = "reset";
    for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_lui_x0();
    test_reg_imm();
    test_shifts();
    test_reg_reg();
    test_credit_flow();
    test_illegal_halt();
    $display("%0d tests run, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/rv_int_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_int_core
  import rv_int_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        insn_valid,
  input  wire word_t insn,
  output logic       insn_credit,
  output logic       retire_valid,
  output reg_idx_t   retire_rd,
  output word_t      retire_data,
  output logic       halt
);

  // queue to decode
  logic head_valid;
  word_t head_insn;
  logic pop;

  // register file ports
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t rs1_data;
  word_t rs2_data;
  logic we;
  word_t wb_data;

  // execute
  word_t operand_a;
  word_t operand_b;
  exec_op_t op;
  logic use_shift_logic;
  logic issue_legal;
  logic issue_illegal;
  word_t arith_result;
  word_t shift_logic_result;

  insn_queue u_queue (
    .clk(clk),
    .rst(rst),
    .insn_valid(insn_valid),
    .insn(insn),
    .halt(halt),
    .head_valid(head_valid),
    .head_insn(head_insn),
    .pop(pop),
    .insn_credit(insn_credit)
  );

  insn_decode u_decode (
    .head_valid(head_valid),
    .head_insn(head_insn),
    .pop(pop),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .op(op),
    .use_shift_logic(use_shift_logic),
    .issue_legal(issue_legal),
    .issue_illegal(issue_illegal)
  );

  reg_file u_regs (
    .clk(clk),
    .rst(rst),
    .we(we),
    .rd(rd),
    .rd_data(wb_data),
    .rs1(rs1),
    .rs2(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  arith_unit u_arith (
    .operand_a(operand_a),
    .operand_b(operand_b),
    .op(op),
    .arith_result(arith_result)
  );

  shift_logic_unit u_shift_logic (
    .operand_a(operand_a),
    .operand_b(operand_b),
    .op(op),
    .shift_logic_result(shift_logic_result)
  );

  writeback_select u_writeback (
    .clk(clk),
    .rst(rst),
    .issue_legal(issue_legal),
    .issue_illegal(issue_illegal),
    .use_shift_logic(use_shift_logic),
    .rd(rd),
    .arith_result(arith_result),
    .shift_logic_result(shift_logic_result),
    .we(we),
    .wb_data(wb_data),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .halt(halt)
  );

endmodule

`default_nettype wire

// File: verilog/writeback_select.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_select
  import rv_int_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire           issue_legal,
  input  wire           issue_illegal,
  input  wire           use_shift_logic,
  input  wire reg_idx_t rd,
  input  wire word_t    arith_result,
  input  wire word_t    shift_logic_result,
  output logic          we,
  output word_t         wb_data,
  output logic          retire_valid,
  output reg_idx_t      retire_rd,
  output word_t         retire_data,
  output logic          halt
);

  // register write happens at the issue edge
  assign wb_data = use_shift_logic ? shift_logic_result : arith_result;
  assign we = issue_legal;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      retire_valid <= 1'b0;
      halt <= 1'b0;
    end else begin
      retire_valid <= issue_legal;
      // sticky until reset
      if (issue_illegal) begin
        halt <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_legal) begin
      retire_rd <= rd;
      retire_data <= wb_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/shift_logic_unit.sv
`timescale 1ns/1ns
`default_nettype none

module shift_logic_unit
  import rv_int_pkg::*;
(
  input  wire word_t    operand_a,
  input  wire word_t    operand_b,
  input  wire exec_op_t op,
  output word_t         shift_logic_result
);

  logic [4:0] shamt;
  word_t sra_value;

  // only the low five bits count
  assign shamt = operand_b[4:0];

  // arithmetic shift keeps the sign
  assign sra_value = word_t'($signed(operand_a) >>> shamt);

  always_comb begin
    case (op)
      exec_sll: shift_logic_result = operand_a << shamt;
      exec_srl: shift_logic_result = operand_a >> shamt;
      exec_sra: shift_logic_result = sra_value;
      exec_xor: shift_logic_result = operand_a ^ operand_b;
      exec_or: shift_logic_result = operand_a | operand_b;
      exec_and: shift_logic_result = operand_a & operand_b;
      default: shift_logic_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/arith_unit.sv
`timescale 1ns/1ns
`default_nettype none

module arith_unit
  import rv_int_pkg::*;
(
  input  wire word_t    operand_a,
  input  wire word_t    operand_b,
  input  wire exec_op_t op,
  output word_t         arith_result
);

  logic subtract;
  word_t b_in;
  logic [xlen:0] sum_ext;
  logic lt_signed;
  logic lt_unsigned;

  // sub and both compares use a - b
  assign subtract = op inside {exec_sub, exec_slt, exec_sltu};
  assign b_in = subtract ? ~operand_b : operand_b;
  assign sum_ext = {1'b0, operand_a} + {1'b0, b_in} + {{xlen{1'b0}}, subtract};

  // no carry out of a - b means a < b unsigned
  assign lt_unsigned = !sum_ext[xlen];
  // sign of the difference, unless the operand signs differ
  assign lt_signed = (operand_a[xlen-1] != operand_b[xlen-1]) ? operand_a[xlen-1]
                                                              : sum_ext[xlen-1];

  always_comb begin
    case (op)
      exec_slt: arith_result = {{(xlen-1){1'b0}}, lt_signed};
      exec_sltu: arith_result = {{(xlen-1){1'b0}}, lt_unsigned};
      exec_lui: arith_result = operand_b;
      default: arith_result = sum_ext[xlen-1:0];
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file
  import rv_int_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire           we,
  input  wire reg_idx_t rd,
  input  wire word_t    rd_data,
  input  wire reg_idx_t rs1,
  input  wire reg_idx_t rs2,
  output word_t         rs1_data,
  output word_t         rs2_data
);

  word_t regs [num_regs];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      // x0 stays zero
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/insn_decode.sv
`timescale 1ns/1ns
`default_nettype none

module insn_decode
  import rv_int_pkg::*;
(
  input  wire        head_valid,
  input  wire word_t head_insn,
  input  wire        pop,
  input  wire word_t rs1_data,
  input  wire word_t rs2_data,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output reg_idx_t   rd,
  output word_t      operand_a,
  output word_t      operand_b,
  output exec_op_t   op,
  output logic       use_shift_logic,
  output logic       issue_legal,
  output logic       issue_illegal
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t imm_i;
  word_t imm_u;
  exec_op_t alu_op;
  logic is_lui;
  logic is_reg_imm;
  logic is_reg_reg;
  logic f7_alt;
  logic f7_checked;
  logic f7_ok;
  logic known;
  logic issue;

  // R/I field split
  assign opcode = head_insn[6:0];
  assign rd = head_insn[11:7];
  assign funct3 = head_insn[14:12];
  assign rs1 = head_insn[19:15];
  assign rs2 = head_insn[24:20];
  assign funct7 = head_insn[31:25];

  assign imm_i = {{20{head_insn[31]}}, head_insn[31:20]};
  assign imm_u = {head_insn[31:12], 12'b0};

  assign is_lui = (opcode == op_lui);
  assign is_reg_imm = (opcode == op_reg_imm);
  assign is_reg_reg = (opcode == op_reg_reg);

  // funct7 only matters for register ops and immediate shifts
  assign f7_alt = (funct7 == funct7_alt);
  assign f7_checked = is_reg_reg || (funct3 == funct3_sll) || (funct3 == funct3_srl);
  assign f7_ok = !f7_checked || (funct7 == funct7_base) ||
                 (f7_alt && ((funct3 == funct3_srl) || (is_reg_reg && funct3 == funct3_add)));

  always_comb begin
    case (funct3)
      funct3_add: alu_op = (is_reg_reg && f7_alt) ? exec_sub : exec_add;
      funct3_sll: alu_op = exec_sll;
      funct3_slt: alu_op = exec_slt;
      funct3_sltu: alu_op = exec_sltu;
      funct3_xor: alu_op = exec_xor;
      funct3_srl: alu_op = f7_alt ? exec_sra : exec_srl;
      funct3_or: alu_op = exec_or;
      default: alu_op = exec_and;
    endcase
  end

  assign op = is_lui ? exec_lui : alu_op;
  assign use_shift_logic = op inside {exec_sll, exec_srl, exec_sra, exec_xor, exec_or, exec_and};

  assign operand_a = rs1_data;
  assign operand_b = is_lui ? imm_u : (is_reg_reg ? rs2_data : imm_i);

  // anything outside the kept set stops the core
  assign known = is_lui || ((is_reg_imm || is_reg_reg) && f7_ok);
  assign issue = pop && head_valid;
  assign issue_legal = issue && known;
  assign issue_illegal = issue && !known;

endmodule

`default_nettype wire

// File: verilog/insn_queue.sv
`timescale 1ns/1ns
`default_nettype none

module insn_queue
  import rv_int_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        insn_valid,
  input  wire word_t insn,
  input  wire        halt,
  output logic       head_valid,
  output word_t      head_insn,
  output logic       pop,
  output logic       insn_credit
);

  word_t slots [credit_depth];

  // depth is a power of two, so the pointers wrap on their own
  logic [$clog2(credit_depth)-1:0] wr_ptr;
  logic [$clog2(credit_depth)-1:0] rd_ptr;
  logic [$clog2(credit_depth+1)-1:0] count;

  assign head_valid = (count != 0);
  assign head_insn = slots[rd_ptr];

  // no issue once the core has stopped
  assign pop = head_valid && !halt;

  always_ff @(posedge clk) begin
    if (insn_valid) begin
      slots[wr_ptr] <= insn;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      insn_credit <= 1'b0;
    end else begin
      if (insn_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({insn_valid, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit back per popped slot
      insn_credit <= pop;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rv_int_pkg.sv
`default_nettype none

package rv_int_pkg;

  // RV32 register and instruction width
  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [3:0] exec_op_t;

  // major opcodes kept by this core
  localparam opcode_t op_lui = 7'b01_101_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;

  // funct3, shared by the immediate and register groups
  localparam funct3_t funct3_add = 3'b000;
  localparam funct3_t funct3_sll = 3'b001;
  localparam funct3_t funct3_slt = 3'b010;
  localparam funct3_t funct3_sltu = 3'b011;
  localparam funct3_t funct3_xor = 3'b100;
  localparam funct3_t funct3_srl = 3'b101;
  localparam funct3_t funct3_or = 3'b110;
  localparam funct3_t funct3_and = 3'b111;

  // alt selects sub and sra
  localparam funct7_t funct7_base = 7'b0000000;
  localparam funct7_t funct7_alt = 7'b0100000;

  // execute operations
  localparam exec_op_t exec_add = 4'd0;
  localparam exec_op_t exec_sub = 4'd1;
  localparam exec_op_t exec_slt = 4'd2;
  localparam exec_op_t exec_sltu = 4'd3;
  localparam exec_op_t exec_lui = 4'd4;
  localparam exec_op_t exec_sll = 4'd5;
  localparam exec_op_t exec_srl = 4'd6;
  localparam exec_op_t exec_sra = 4'd7;
  localparam exec_op_t exec_xor = 4'd8;
  localparam exec_op_t exec_or = 4'd9;
  localparam exec_op_t exec_and = 4'd10;

  // sender credits after reset, equal to the queue depth
  localparam int credit_depth = 2;

endpackage

`default_nettype wire
